// File: opc5_cpu.f
+incdir+source
+incdir+verif
source/opc5_pkg.sv
source/opc5_sequencer.sv
source/opc5_regfile.sv
source/opc5_alu.sv
source/opc5_fetch_unit.sv
source/opc5_cpu.sv
verif/opc5_cpu_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert -Wno-fatal -f opc5_cpu.f --top-module opc5_cpu_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vopc5_cpu_tb)"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// File: verif/opc5_isa_model.svh
`ifndef OPC5_ISA_MODEL_SVH
`define OPC5_ISA_MODEL_SVH

// Architectural state of the reference model
logic [15:0]  m_mem [1024];
logic [15:0]  m_reg [16];
logic [15:0]  m_pc;
logic         m_c;
logic         m_z;
opc5_wb_req_t exp_q [$];          // Expected bus cycles, oldest first

function automatic opc5_wb_req_t bus_cycle(input logic we, input logic [15:0] adr,
                                           input logic [15:0] dat);
   return '{1'b1, 1'b1, we, adr, dat};
endfunction

// r0 reads zero and r15 reads the address of the next instruction
function automatic logic [15:0] reg_value(input logic [3:0] idx);
   if (idx == 4'd0)
      return 16'h0000;
   else if (idx == 4'd15)
      return m_pc;
   return m_reg[idx];
endfunction

task automatic model_reset();
   m_mem = mem;
   m_pc = 16'h0000;
   m_c = 1'b0;
   m_z = 1'b0;
   exp_q.delete();
endtask

// Executes one instruction and queues the bus cycles it causes
task automatic model_step();
   opc5_instr_t ins;
   logic [15:0] opw;
   logic [15:0] opnd;
   logic [15:0] dv;
   logic [15:0] res;
   logic [16:0] sum;
   ins = m_mem[m_pc[9:0]];
   exp_q.push_back(bus_cycle(1'b0, m_pc, 16'h0000));
   m_pc = m_pc + 16'd1;
   opw = m_mem[m_pc[9:0]];
   exp_q.push_back(bus_cycle(1'b0, m_pc, 16'h0000));
   m_pc = m_pc + 16'd1;
   if (!(ins.pred_c || ins.pred_z || m_c || m_z))
      return;                     // Skipped, only the two fetches are seen
   opnd = reg_value(ins.src) + opw;
   if (ins.mem)
   begin
      exp_q.push_back(bus_cycle(1'b0, opnd, 16'h0000));
      opnd = m_mem[opnd[9:0]];
   end
   dv = reg_value(ins.dst);
   sum = {1'b0, dv} + {1'b0, opnd};
   case (ins.op)
      LD     : res = opnd;
      ADD    : res = sum[15:0];
      NAND   : res = ~(dv & opnd);
      default:
      begin
         exp_q.push_back(bus_cycle(1'b1, opnd, dv));
         m_mem[opnd[9:0]] = dv;
         return;
      end
   endcase
   if (ins.op == ADD)
      m_c = sum[16];
   m_z = (res == 16'h0000);
   if (ins.dst == 4'd15)
      m_pc = res;                 // Jump
   else if (ins.dst != 4'd0)
      m_reg[ins.dst] = res;
endtask

// Compares one acked DUT cycle with the oldest expected one
task automatic check_cycle(input opc5_wb_req_t got);
   opc5_wb_req_t exp;
   if (exp_q.size() == 0)
      model_step();
   exp = exp_q.pop_front();
   assert (got.we == exp.we)
   else show_mismatch("we", 16'(exp.we), 16'(got.we));
   assert (got.adr == exp.adr)
   else show_mismatch("adr", exp.adr, got.adr);
   assert (!exp.we || got.dat == exp.dat)
   else show_mismatch("write data", exp.dat, got.dat);
endtask

`endif

// File: verif/opc5_cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module opc5_cpu_tb;

   import opc5_pkg::*;

   logic         clk;
   logic         reset_b;
   opc5_wb_req_t wb_req;
   opc5_wb_rsp_t wb_rsp;
   opc5_wb_req_t held;            // Request as it stood when the current cycle began
   logic [31:0]  lfsr;
   logic [15:0]  mem [1024];      // Slave memory, the address wraps at 1024
   logic         active;
   logic         use_waits;
   int           wait_left;
   int           seen;
   int           errs;
   int           n_pass;
   int           n_fail;
   string        test_name;

   `include "opc5_isa_model.svh"

   opc5_cpu dut (.clk, .reset_b, .wb_req, .wb_rsp);

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      v = '0;
      repeat (n)
      begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);   // Galois step
         v = {v[14:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic show_mismatch(input string what, input logic [15:0] exp,
                                input logic [15:0] act);
      $display("Fail %s: %s expected %h actual %h", test_name, what, exp, act);
      errs++;
   endtask

   task automatic note_error(input string msg);
      $display("Error in %s: %s", test_name, msg);
      errs++;
   endtask

   // Even words hold instructions leaning toward the topic of the test
   task automatic load_program(input int mode);
      opc5_instr_t ins;
      int          a;
      for (a = 0; a < 1024; a++)
      begin
         ins = rand_bits(16);
         if (mode inside {1, 3, 4})
            ins.pred_c = 1'b1;
         if (mode inside {1, 2, 4})
            ins.mem = 1'b0;
         if (mode == 1 && ins.op == ADD)
            ins.op = NAND;
         if (mode == 2 && ins.op == NAND)
            ins.op = ADD;             // Plenty of carries feeding the predicates
         if (mode == 3)
            ins.op = ins.spare0 ? STO : LD;
         if (mode == 4 && ins.spare1[0])
            ins.dst = ins.spare1[1] ? 4'd15 : 4'd0;
         if (a[0])
            mem[a] = rand_bits(16);
         else
            mem[a] = ins;
      end
      // A run of LD instructions gives r1 to r14 known values
      for (a = 1; a < 15; a++)
      begin
         ins = '0;
         ins.pred_c = 1'b1;
         ins.op = LD;
         ins.dst = 4'(a);
         mem[2 * a - 2] = ins;
      end
   endtask

   // ########################################################################
   // Wishbone slave, called on each falling edge
   // ########################################################################

   task automatic serve_bus();
      if (wb_rsp.ack)
      begin
         wb_rsp.ack = 1'b0;       // The cycle ended on the rising edge just passed
         active = 1'b0;
      end
      if (!wb_req.cyc || !wb_req.stb)
      begin
         assert (!active)
         else note_error("bus cycle dropped before its ack");
         active = 1'b0;
         return;
      end
      if (!active)
      begin
         active = 1'b1;
         held = wb_req;
         wait_left = use_waits ? int'(rand_bits(2)) : 0;
      end
      else
      begin
         assert ({wb_req.we, wb_req.adr} == {held.we, held.adr} &&
                 (!wb_req.we || wb_req.dat == held.dat))
         else note_error("address, we or write data changed while waiting for ack");
      end
      if (wait_left > 0)
      begin
         wait_left--;
         return;
      end
      check_cycle(wb_req);
      if (wb_req.we)
         mem[wb_req.adr[9:0]] = wb_req.dat;
      else
         wb_rsp.dat = mem[wb_req.adr[9:0]];
      wb_rsp.ack = 1'b1;
      seen++;
   endtask

   // ########################################################################
   // Test sequence
   // ########################################################################

   task automatic run_test(input string name, input int mode, input logic waits,
                           input int n);
      int cycles;
      test_name = name;
      errs = 0;
      seen = 0;
      cycles = 0;
      use_waits = waits;
      load_program(mode);
      reset_b = 1'b0;
      wb_rsp = '0;
      active = 1'b0;
      repeat (8) @(negedge clk);
      model_reset();
      reset_b = 1'b1;
      while (seen < n && cycles < 10 * n + 100)
      begin
         @(negedge clk);
         serve_bus();
         cycles++;
      end
      assert (seen >= n)
      else note_error($sformatf("timed out after %0d of %0d bus cycles", seen, n));
      if (errs == 0)
         n_pass++;
      else
         n_fail++;
      $display("%s: %0d bus cycles, %0d errors", name, seen, errs);
   endtask

   initial
   begin
      reset_b = 1'b0;
      wb_rsp = '0;
      lfsr = 32'h2023;
      n_pass = 0;
      n_fail = 0;
      run_test("reset_and_fetch", 0, 1'b0, 8);
      run_test("ld_nand_sto", 1, 1'b0, 600);
      run_test("add_carry_zero", 2, 1'b0, 600);
      run_test("indirect_ld_sto", 3, 1'b0, 600);
      run_test("r15_jump_r0_zero", 4, 1'b0, 600);
      run_test("wait_states", 0, 1'b1, 600);
      $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
      if (n_fail == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: source/opc5_cpu.sv
`timescale 1ns/10ps
`default_nettype none

`include "opc5_config.svh"

module opc5_cpu
(
   input  wire logic                   clk,
   input  wire logic                   reset_b,
   output opc5_pkg::opc5_wb_req_t      wb_req,
   input  wire opc5_pkg::opc5_wb_rsp_t wb_rsp
);

   import opc5_pkg::*;

   opc5_state_t             state;
   opc5_instr_t             instr;
   opc5_flags_t             flags;
   logic                    bus_req, bus_we, bus_done;
   logic                    load_ir, load_or, add_ea, inc_pc, write_pc;
   logic                    rd_sel, reg_we, flag_we;
   logic [`OPC5_DATA_W-1:0] reg_data;
   logic [`OPC5_DATA_W-1:0] result;
   logic [`OPC5_DATA_W-1:0] operand;
   logic [`OPC5_DATA_W-1:0] pc;

   opc5_sequencer u_sequencer (
      .clk, .reset_b, .instr, .flags, .bus_done, .state,
      .bus_req, .bus_we, .load_ir, .load_or, .add_ea, .inc_pc,
      .write_pc, .rd_sel, .reg_we, .flag_we
   );

   opc5_regfile u_regfile (
      .clk, .rd_sel, .we(reg_we), .instr, .pc, .wdata(result), .rdata(reg_data)
   );

   // Destination register on a, operand word on b
   opc5_alu u_alu (
      .clk, .reset_b, .instr, .a(reg_data), .b(operand), .flag_we, .result, .flags
   );

   opc5_fetch_unit u_fetch_unit (
      .clk, .reset_b, .load_ir, .load_or, .add_ea, .inc_pc, .bus_req, .bus_we,
      .state, .reg_data, .result, .write_pc, .instr, .operand, .pc, .bus_done,
      .wb_req, .wb_rsp
   );

endmodule

`default_nettype wire

// File: source/opc5_fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "opc5_config.svh"

module opc5_fetch_unit
(
   input  wire logic                    clk,
   input  wire logic                    reset_b,
   input  wire logic                    load_ir,
   input  wire logic                    load_or,
   input  wire logic                    add_ea,
   input  wire logic                    inc_pc,
   input  wire logic                    bus_req,
   input  wire logic                    bus_we,
   input  wire opc5_pkg::opc5_state_t   state,
   input  wire logic [`OPC5_DATA_W-1:0] reg_data,
   input  wire logic [`OPC5_DATA_W-1:0] result,
   input  wire logic                    write_pc,
   output opc5_pkg::opc5_instr_t        instr,
   output logic [`OPC5_DATA_W-1:0]      operand,
   output logic [`OPC5_DATA_W-1:0]      pc,
   output logic                         bus_done,
   output opc5_pkg::opc5_wb_req_t       wb_req,
   input  wire opc5_pkg::opc5_wb_rsp_t  wb_rsp
);

   import opc5_pkg::*;

   logic cyc_q;
   logic we_q;
   logic use_or;

   // ########################################################################
   // Program counter, instruction and operand registers
   // ########################################################################

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         pc <= '0;
      else if (write_pc)
         pc <= result;           // Jump through r15
      else if (inc_pc)
         pc <= pc + 1'b1;
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         instr <= '0;
      else if (load_ir)
         instr <= wb_rsp.dat;
   end

   // Second word, then effective address, then memory data if requested
   always_ff @(posedge clk)
   begin
      if (load_or)
         operand <= wb_rsp.dat;
      else if (add_ea)
         operand <= operand + reg_data;
   end

   // ########################################################################
   // Wishbone master
   // ########################################################################

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         cyc_q <= 1'b0;
         we_q  <= 1'b0;
      end
      else
      begin
         cyc_q <= bus_req;       // Stays up when the next access follows directly
         we_q  <= bus_we;
      end
   end

   assign use_or   = (state == RDMEM) || (state == EXEC);
   assign bus_done = wb_rsp.ack & cyc_q;

   always_comb
   begin
      wb_req.cyc = cyc_q;
      wb_req.stb = cyc_q;
      wb_req.we  = we_q;
      wb_req.adr = use_or ? operand : pc;
      wb_req.dat = reg_data;     // Destination register during a STO
   end

endmodule

`default_nettype wire

// File: source/opc5_alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "opc5_config.svh"

module opc5_alu
(
   input  wire logic                    clk,
   input  wire logic                    reset_b,
   input  wire opc5_pkg::opc5_instr_t   instr,
   input  wire logic [`OPC5_DATA_W-1:0] a,
   input  wire logic [`OPC5_DATA_W-1:0] b,
   input  wire logic                    flag_we,
   output logic [`OPC5_DATA_W-1:0]      result,
   output opc5_pkg::opc5_flags_t        flags
);

   import opc5_pkg::*;

   logic [`OPC5_DATA_W:0] sum;   // Top bit is the carry out

   assign sum = {1'b0, a} + {1'b0, b};

   // a is the destination register, b the operand
   always_comb
   begin
      case (instr.op)
         LD     : result = b;
         ADD    : result = sum[`OPC5_DATA_W-1:0];
         NAND   : result = ~(a & b);
         default: result = a;    // Store data, never written back
      endcase
   end

   // ########################################################################
   // Flag registers
   // ########################################################################

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         flags <= '0;
      end
      else if (flag_we)
      begin
         flags.z <= ~|result;
         if (instr.op == ADD)
            flags.c <= sum[`OPC5_DATA_W];   // Carry only changes on ADD
      end
   end

endmodule

`default_nettype wire

// File: source/opc5_regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "opc5_config.svh"

module opc5_regfile
(
   input  wire logic                    clk,
   input  wire logic                    rd_sel,
   input  wire logic                    we,
   input  wire opc5_pkg::opc5_instr_t   instr,
   input  wire logic [`OPC5_DATA_W-1:0] pc,
   input  wire logic [`OPC5_DATA_W-1:0] wdata,
   output logic [`OPC5_DATA_W-1:0]      rdata
);

   localparam int IDX_W = $clog2(`OPC5_NUM_REGS);

   logic [`OPC5_DATA_W-1:0] regs [`OPC5_NUM_REGS];
   logic [IDX_W-1:0]        rd_idx;
   logic                    wr_ok;

   assign rd_idx = rd_sel ? instr.dst : instr.src;

   // r0 is a constant zero and r15 mirrors the next instruction address
   always_comb
   begin
      if (rd_idx == '0)
         rdata = '0;
      else if (rd_idx == IDX_W'(`OPC5_PC_REG))
         rdata = pc;
      else
         rdata = regs[rd_idx];
   end

   // r15 writes go to the PC in the fetch unit instead
   assign wr_ok = (instr.dst != '0) && (instr.dst != IDX_W'(`OPC5_PC_REG));

   always_ff @(posedge clk)
   begin
      if (we && wr_ok)
         regs[instr.dst] <= wdata;
   end

endmodule

`default_nettype wire

// File: source/opc5_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "opc5_config.svh"

module opc5_sequencer
(
   input  wire logic                  clk,
   input  wire logic                  reset_b,
   input  wire opc5_pkg::opc5_instr_t instr,
   input  wire opc5_pkg::opc5_flags_t flags,
   input  wire logic                  bus_done,
   output opc5_pkg::opc5_state_t      state,
   output logic                       bus_req,
   output logic                       bus_we,
   output logic                       load_ir,
   output logic                       load_or,
   output logic                       add_ea,
   output logic                       inc_pc,
   output logic                       write_pc,
   output logic                       rd_sel,
   output logic                       reg_we,
   output logic                       flag_we
);

   import opc5_pkg::*;

   logic [`OPC5_DATA_W-1:0] instr_bits;
   logic                    skip;
   logic                    is_sto;
   opc5_state_t             next_state;

   assign instr_bits = instr;
   assign is_sto     = (instr.op == STO);

   // Skipped only when both predicate bits and both flags are clear
   assign skip = ~(instr_bits[`OPC5_PRED_C_BIT] | instr_bits[`OPC5_PRED_Z_BIT] |
                   flags.c | flags.z);

   // ########################################################################
   // State register and next state
   // ########################################################################

   always_comb
   begin
      next_state = state;
      case (state)
         FETCH0 : if (bus_done) next_state = FETCH1;
         FETCH1 : if (bus_done) next_state = EA_ED;
         EA_ED  :
         begin
            if (skip)
               next_state = FETCH0;
            else if (instr_bits[`OPC5_MEM_BIT])
               next_state = RDMEM;
            else
               next_state = EXEC;
         end
         RDMEM  : if (bus_done) next_state = EXEC;
         EXEC   : if (!is_sto || bus_done) next_state = FETCH0;  // STO waits for its ack
         default: next_state = FETCH0;
      endcase
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         state <= FETCH0;
      else
         state <= next_state;
   end

   // Bus request looks one state ahead, the fetch unit registers it
   assign bus_req = (next_state == FETCH0) || (next_state == FETCH1) ||
                    (next_state == RDMEM)  || (next_state == EXEC && is_sto);
   assign bus_we  = (next_state == EXEC) && is_sto;

   // Instruction is finished with its fetch once each word is acked
   assign load_ir = (state == FETCH0) && bus_done;
   assign inc_pc  = ((state == FETCH0) || (state == FETCH1)) && bus_done;
   assign load_or = ((state == FETCH1) || (state == RDMEM)) && bus_done;
   assign add_ea  = (state == EA_ED);

   assign rd_sel   = (state == EXEC);          // Destination in EXEC, source otherwise
   assign reg_we   = (state == EXEC) && !is_sto;
   assign flag_we  = reg_we;
   assign write_pc = reg_we && (instr.dst == 4'(`OPC5_PC_REG));

endmodule

`default_nettype wire

// File: source/opc5_pkg.sv
`default_nettype none

`include "opc5_config.svh"

package opc5_pkg;

   // Instruction cycle states, each instruction passes FETCH0 to EA_ED
   typedef enum logic [2:0] {
      FETCH0 = 3'd0,
      FETCH1 = 3'd1,
      EA_ED  = 3'd2,
      RDMEM  = 3'd3,
      EXEC   = 3'd4
   } opc5_state_t;

   typedef enum logic [1:0] {
      LD   = 2'b00,
      ADD  = 2'b01,
      NAND = 2'b10,
      STO  = 2'b11
   } opc5_op_t;

   // First instruction word, the operand is the second word
   typedef struct packed {
      logic       pred_c;
      logic       pred_z;
      logic       spare0;
      logic       mem;      // Read memory at the effective address first
      opc5_op_t   op;
      logic [1:0] spare1;
      logic [3:0] src;
      logic [3:0] dst;
   } opc5_instr_t;

   typedef struct packed {
      logic                    cyc;
      logic                    stb;
      logic                    we;
      logic [`OPC5_DATA_W-1:0] adr;
      logic [`OPC5_DATA_W-1:0] dat;
   } opc5_wb_req_t;

   typedef struct packed {
      logic                    ack;
      logic [`OPC5_DATA_W-1:0] dat;
   } opc5_wb_rsp_t;

   typedef struct packed {
      logic c;
      logic z;
   } opc5_flags_t;

endpackage

`default_nettype wire

// File: source/opc5_config.svh
`ifndef OPC5_CONFIG_SVH
`define OPC5_CONFIG_SVH

// Datapath and bus address width
`define OPC5_DATA_W      16

// Register file size and the register that aliases the PC
`define OPC5_NUM_REGS    16
`define OPC5_PC_REG      15

// Bit positions inside the first instruction word
`define OPC5_PRED_C_BIT  15
`define OPC5_PRED_Z_BIT  14
`define OPC5_MEM_BIT     12

`endif
